//--- dv/fft_vectors.txt
# mode (0 forward, 1 inverse), four input samples as re im,
# then the four expected outputs X0 X1 X2 X3 as re im
0 1 0 0 0 0 0 0 0 1 0 1 0 1 0 1 0
0 1 0 1 0 1 0 1 0 4 0 0 0 0 0 0 0
0 1 2 3 4 5 6 7 8 16 20 -8 0 -4 -4 0 -8
1 16 20 -8 0 -4 -4 0 -8 1 2 3 4 5 6 7 8
0 100 -50 -30 20 7 9 -11 -3 66 -24 116 -40 148 -58 70 -78
1 66 -24 116 -40 148 -58 70 -78 100 -50 -30 20 7 9 -11 -3
1 1 -1 2 -3 0 0 0 0 0 -1 1 0 -1 0 -1 -1
0 32767 32767 32767 32767 32767 32767 32767 32767 131068 131068 0 0 0 0 0 0
0 32767 -32768 -32768 32767 32767 -32768 -32768 32767 -2 -2 0 0 131070 -131070 0 0
1 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 0 0 0 0 0 0
0 1 0 0 1 -1 0 0 -1 0 0 4 0 0 0 0 0
1 1 0 0 1 -1 0 0 -1 0 0 0 0 0 0 1 0
0 1234 -567 -890 321 -45 678 999 -1000 1298 -568 2600 644 1080 790 -42 -3134
1 5 -7 -3 2 10 1 -6 -9 1 -4 -4 -2 6 0 1 -3

//--- list.f
+incdir+common
common/fftPkg.sv
control/fftControl.sv
source/sampleLoader.sv
source/butterflyEngine.sv
source/resultUnloader.sv
source/fftAccel.sv
dv/fftAccel_chk.sv
dv/fftAccelTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fftAccel regression with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module fftAccelTb -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/VfftAccelTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

//--- dv/fftAccelTb.sv
`timescale 1ns/10ps
`include "fft_defs.svh"

module fftAccelTb import fftPkg::*; ();

    localparam int MaxJobs = 32;
    localparam int JobCycles = 40;
    localparam int EofChar = -1;
    localparam int SpaceChar = 32;
    localparam int HashChar = 35;
    localparam int NewlineChar = 10;
    localparam int ZeroChar = 48;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       startF = 1'b0;
    logic       startI = 1'b0;
    cplxSampleT inData = '0;
    logic       inValid = 1'b0;
    logic       inReady;
    cplxResultT outData;
    logic       outValid;
    logic       outReady = 1'b0;
    logic       busy;
    logic       done;

    int   jobMode [MaxJobs];
    int   vecIn [MaxJobs][2*`FFT_POINTS];
    int   vecExp [MaxJobs][2*`FFT_POINTS];
    int   numJobs = 0;
    int   seed = 32'h5b600a0c;
    int   valueErrors = 0;
    int   protocolErrors = 0;
    int   doneCount = 0;
    logic vectorsLoaded = 1'b0;
    logic jobDone = 1'b0;

    fftAccel dut (
        .clk     (clk),
        .rst     (rst),
        .startF  (startF),
        .startI  (startI),
        .inData  (inData),
        .inValid (inValid),
        .inReady (inReady),
        .outData (outData),
        .outValid(outValid),
        .outReady(outReady),
        .busy    (busy),
        .done    (done)
    );

    // 100 ns period
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && done) begin
            doneCount++;
        end
    end

    task automatic noteMismatch(string name, int beat, int expected, int actual);
        valueErrors++;
        $display("** Error at %0t ns: %s beat %0d expected %0d, got %0d",
            $time, name, beat, expected, actual);
    endtask

    task automatic flagFailure(string what);
        protocolErrors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // Inputs change a little after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #5;
    endtask

    //////////////////////////////
    // Vector file
    //////////////////////////////

    task automatic readVectors();
        int fd;
        int c;
        int n;
        fd = $fopen("dv/fft_vectors.txt", "r");
        if (fd == 0) begin
            flagFailure("cannot open dv/fft_vectors.txt");
            return;
        end
        c = $fgetc(fd);
        while (c != EofChar && numJobs < MaxJobs) begin
            if (c == HashChar) begin
                while (c != NewlineChar && c != EofChar) begin
                    c = $fgetc(fd);
                end
            end else if (c > SpaceChar) begin
                // Mode digit first, then sixteen numbers
                jobMode[numJobs] = c - ZeroChar;
                n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    vecIn[numJobs][0], vecIn[numJobs][1], vecIn[numJobs][2],
                    vecIn[numJobs][3], vecIn[numJobs][4], vecIn[numJobs][5],
                    vecIn[numJobs][6], vecIn[numJobs][7],
                    vecExp[numJobs][0], vecExp[numJobs][1], vecExp[numJobs][2],
                    vecExp[numJobs][3], vecExp[numJobs][4], vecExp[numJobs][5],
                    vecExp[numJobs][6], vecExp[numJobs][7]);
                if (n != 2*2*`FFT_POINTS || jobMode[numJobs] > 1) begin
                    flagFailure("malformed line in the vector file");
                    break;
                end
                numJobs++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Job processes
    //////////////////////////////

    task automatic feedSamples(int job);
        int   idx;
        logic sent;
        idx = 0;
        while (idx < `FFT_POINTS) begin
            // Random gaps between beats, never inside one
            if (!inValid && ($random(seed) & 3) != 0) begin
                inData.re = sampleT'(vecIn[job][2*idx]);
                inData.im = sampleT'(vecIn[job][2*idx+1]);
                inValid = 1'b1;
            end
            @(negedge clk);
            sent = inValid && inReady;
            stepCycle();
            if (sent) begin
                idx++;
                inValid = 1'b0;
            end
        end
        // Full buffer takes nothing more
        while (!jobDone) begin
            @(negedge clk);
            assert (!inReady) else flagFailure("inReady high after four input beats");
        end
    endtask

    task automatic checkBeat(int job, int beat);
        int expRe;
        int expIm;
        expRe = vecExp[job][2*beat];
        expIm = vecExp[job][2*beat+1];
        assert (int'(outData.re) == expRe)
            else noteMismatch("outData.re", beat, expRe, int'(outData.re));
        assert (int'(outData.im) == expIm)
            else noteMismatch("outData.im", beat, expIm, int'(outData.im));
    endtask

    task automatic collectResults(int job);
        int         beat;
        logic       gotDone;
        logic       stalled;
        cplxResultT heldData;
        beat = 0;
        gotDone = 1'b0;
        stalled = 1'b0;
        heldData = '0;
        while (!gotDone) begin
            outReady = (($random(seed) & 3) != 0);
            @(negedge clk);
            if (stalled) begin
                assert (outValid && outData == heldData)
                    else flagFailure("output beat dropped or changed during a stall");
            end
            if (done) begin
                assert (beat == `FFT_POINTS) else flagFailure("done before the last output beat");
                assert (busy) else flagFailure("done high while busy low");
                gotDone = 1'b1;
                jobDone = 1'b1;
            end
            if (outValid && outReady) begin
                if (beat < `FFT_POINTS) begin
                    checkBeat(job, beat);
                end else begin
                    flagFailure("extra output beat");
                end
                beat++;
            end
            stalled = outValid && !outReady;
            heldData = outData;
            stepCycle();
        end
    endtask

    // Mid job start pulse that must be ignored
    task automatic strayStart();
        stepCycle();
        startI = 1'b1;
        stepCycle();
        startI = 1'b0;
    endtask

    task automatic runJob(int job);
        assert (!busy) else flagFailure("busy high before a job start");
        if (jobMode[job] == 0) begin
            startF = 1'b1;
        end else begin
            startI = 1'b1;
        end
        stepCycle();
        startF = 1'b0;
        startI = 1'b0;
        jobDone = 1'b0;
        assert (busy) else flagFailure("busy low after a start pulse");
        fork
            feedSamples(job);
            collectResults(job);
            begin
                if (jobMode[job] == 0) begin
                    strayStart();
                end
            end
        join
        stepCycle();
        @(negedge clk);
        assert (!busy && !done) else flagFailure("busy or done high after the job ended");
        stepCycle();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        readVectors();
        vectorsLoaded = 1'b1;
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        assert (!busy && !done && !inReady && !outValid)
            else flagFailure("outputs not idle after reset");
        stepCycle();
        for (int job = 0; job < numJobs; job++) begin
            runJob(job);
        end
        assert (numJobs > 0) else flagFailure("no jobs in the vector file");
        assert (doneCount == numJobs) else flagFailure("done pulse count differs from job count");
        $display("Error counts: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the job count
    initial begin
        wait (vectorsLoaded);
        repeat (numJobs * JobCycles + 20) @(posedge clk);
        $display("Timeout: jobs still running after %0d cycles", numJobs * JobCycles + 20);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- dv/fftAccel_chk.sv
`timescale 1ns/10ps

module fftAccel_chk import fftPkg::*; (
    input logic       clk,
    input logic       rst,
    input cplxResultT outData,
    input logic       outValid,
    input logic       outReady,
    input logic       loadExternal,
    input logic       loadInternal,
    input logic       loadOutBuffer,
    input logic       busy,
    input logic       done
);

    // A stalled beat stays put
    stallHold: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("outData or outValid changed during a stall");

    onePhase: assert property (@(posedge clk) disable iff (rst)
        $onehot0({loadExternal, loadInternal, loadOutBuffer}))
        else $error("load, calculate and unload overlap");

    doneInJob: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> busy)
        else $error("done rose outside a job");

endmodule

bind fftAccel fftAccel_chk chk (
    .clk          (clk),
    .rst          (rst),
    .outData      (outData),
    .outValid     (outValid),
    .outReady     (outReady),
    .loadExternal (loadExternal),
    .loadInternal (loadInternal),
    .loadOutBuffer(loadOutBuffer),
    .busy         (busy),
    .done         (done)
);

//--- source/fftAccel.sv
`timescale 1ns/10ps
`include "fft_defs.svh"

module fftAccel import fftPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       startF,
    input  logic       startI,
    input  cplxSampleT inData,
    input  logic       inValid,
    output logic       inReady,
    output cplxResultT outData,
    output logic       outValid,
    input  logic       outReady,
    output logic       busy,
    output logic       done
);

    logic       loadExternal;
    logic       loadInternal;
    logic       isIFFT;
    logic       loadOutBuffer;
    logic       loadExternalDone;
    logic       engineDone;
    logic       outLoadDone;
    cplxSampleT samples [`FFT_POINTS];
    cplxResultT results [`FFT_POINTS];

    // Stream handshakes steer the FSM between idle and active phases
    fftControl control (
        .clk                (clk),
        .rst                (rst),
        .startF             (startF),
        .startI             (startI),
        .startLoadingRam    (inValid),
        .inFifoEmpty        (!inValid),
        .loadExternalDone   (loadExternalDone),
        .done               (engineDone),
        .startLoadingOutFifo(outReady),
        .outFifoReady       (!outReady),
        .outLoadDone        (outLoadDone),
        .loadExternal       (loadExternal),
        .loadInternal       (loadInternal),
        .isIFFT             (isIFFT),
        .loadOutBuffer      (loadOutBuffer),
        .calculating        (busy),
        .aDone              (done)
    );

    sampleLoader loader (
        .clk             (clk),
        .rst             (rst),
        .inData          (inData),
        .inValid         (inValid),
        .loadExternal    (loadExternal),
        .loadInternal    (loadInternal),
        .inReady         (inReady),
        .samples         (samples),
        .loadExternalDone(loadExternalDone)
    );

    butterflyEngine engine (
        .clk         (clk),
        .rst         (rst),
        .samples     (samples),
        .loadInternal(loadInternal),
        .isIFFT      (isIFFT),
        .results     (results),
        .done        (engineDone)
    );

    resultUnloader unloader (
        .clk          (clk),
        .rst          (rst),
        .results      (results),
        .loadOutBuffer(loadOutBuffer),
        .outReady     (outReady),
        .outData      (outData),
        .outValid     (outValid),
        .outLoadDone  (outLoadDone)
    );

endmodule

//--- source/resultUnloader.sv
`timescale 1ns/10ps
`include "fft_defs.svh"

module resultUnloader import fftPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cplxResultT results [`FFT_POINTS],
    input  logic       loadOutBuffer,
    input  logic       outReady,
    output cplxResultT outData,
    output logic       outValid,
    output logic       outLoadDone
);

    localparam pointIdxT LastIdx = pointIdxT'(`FFT_POINTS - 1);

    pointIdxT rdIdx;
    logic     holdQ;
    logic     xfer;

    // A beat once offered stays offered until taken
    assign outValid = (loadOutBuffer || holdQ) && !outLoadDone;
    assign xfer = outValid && outReady;
    assign outData = results[rdIdx];

    //////////////////////////////
    // Read pointer and status
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdIdx <= '0;
            holdQ <= 1'b0;
            outLoadDone <= 1'b0;
        end else begin
            holdQ <= outValid && !outReady;
            if (xfer) begin
                rdIdx <= rdIdx + pointIdxT'(1);
            end
            // Held until the FSM has seen it from IDLE_LOADOUT
            if (xfer && rdIdx == LastIdx) begin
                outLoadDone <= 1'b1;
            end else if (outLoadDone && !loadOutBuffer) begin
                outLoadDone <= 1'b0;
            end
        end
    end

endmodule

//--- source/butterflyEngine.sv
`timescale 1ns/10ps
`include "fft_defs.svh"

module butterflyEngine import fftPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cplxSampleT samples [`FFT_POINTS],
    input  logic       loadInternal,
    input  logic       isIFFT,
    output cplxResultT results [`FFT_POINTS],
    output logic       done
);

    cplxResultT sumAC;
    cplxResultT difAC;
    cplxResultT sumBD;
    cplxResultT difBD;
    cplxResultT rotBD;
    cplxResultT y [`FFT_POINTS];
    logic       s1Valid;
    logic       fired;
    logic       launch;

    function automatic cplxResultT widen(cplxSampleT x);
        cplxResultT w;
        w.re = resultT'(x.re);
        w.im = resultT'(x.im);
        return w;
    endfunction

    function automatic cplxResultT cAdd(cplxResultT x, cplxResultT z);
        cplxResultT s;
        s.re = x.re + z.re;
        s.im = x.im + z.im;
        return s;
    endfunction

    function automatic cplxResultT cSub(cplxResultT x, cplxResultT z);
        cplxResultT s;
        s.re = x.re - z.re;
        s.im = x.im - z.im;
        return s;
    endfunction

    // Multiply by -j
    function automatic cplxResultT negJ(cplxResultT x);
        cplxResultT r;
        r.re = x.im;
        r.im = -x.re;
        return r;
    endfunction

    // Divide by 4 for the inverse, floor rounding
    function automatic cplxResultT scaleInv(cplxResultT x, logic inv);
        cplxResultT s;
        s = x;
        if (inv) begin
            s.re = x.re >>> 2;
            s.im = x.im >>> 2;
        end
        return s;
    endfunction

    // One launch per job
    assign launch = loadInternal && !fired && !s1Valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1Valid <= 1'b0;
            fired <= 1'b0;
            done <= 1'b0;
        end else begin
            s1Valid <= launch;
            done <= s1Valid;
            if (s1Valid) begin
                fired <= 1'b1;
            end else if (!loadInternal) begin
                fired <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Stage one
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (launch) begin
            sumAC <= cAdd(widen(samples[0]), widen(samples[2]));
            difAC <= cSub(widen(samples[0]), widen(samples[2]));
            sumBD <= cAdd(widen(samples[1]), widen(samples[3]));
            difBD <= cSub(widen(samples[1]), widen(samples[3]));
        end
    end

    //////////////////////////////
    // Stage two
    //////////////////////////////

    always_comb begin
        rotBD = negJ(difBD);
        y[0] = cAdd(sumAC, sumBD);
        y[2] = cSub(sumAC, sumBD);
        // Inverse turns the rotation around
        if (isIFFT) begin
            y[1] = cSub(difAC, rotBD);
            y[3] = cAdd(difAC, rotBD);
        end else begin
            y[1] = cAdd(difAC, rotBD);
            y[3] = cSub(difAC, rotBD);
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            for (int i = 0; i < `FFT_POINTS; i++) begin
                results[i] <= scaleInv(y[i], isIFFT);
            end
        end
    end

endmodule

//--- source/sampleLoader.sv
`timescale 1ns/10ps
`include "fft_defs.svh"

module sampleLoader import fftPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cplxSampleT inData,
    input  logic       inValid,
    input  logic       loadExternal,
    input  logic       loadInternal,
    output logic       inReady,
    output cplxSampleT samples [`FFT_POINTS],
    output logic       loadExternalDone
);

    localparam pointIdxT LastIdx = pointIdxT'(`FFT_POINTS - 1);

    pointIdxT wrIdx;
    logic     full;
    logic     loadInternalQ;
    logic     beat;
    logic     newJob;

    assign inReady = loadExternal && !full;
    assign beat = inValid && inReady;
    assign loadExternalDone = full;

    // First calculating cycle frees the buffer for the next job
    assign newJob = loadInternal && !loadInternalQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrIdx <= '0;
            full <= 1'b0;
            loadInternalQ <= 1'b0;
        end else begin
            loadInternalQ <= loadInternal;
            if (newJob) begin
                wrIdx <= '0;
                full <= 1'b0;
            end else if (beat) begin
                wrIdx <= wrIdx + pointIdxT'(1);
                if (wrIdx == LastIdx) begin
                    full <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Sample buffer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (beat) begin
            samples[wrIdx] <= inData;
        end
    end

endmodule

//--- control/fftControl.sv
`timescale 1ns/10ps

module fftControl import fftPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic startF,
    input  logic startI,
    input  logic startLoadingRam,
    input  logic inFifoEmpty,
    input  logic loadExternalDone,
    input  logic done,
    input  logic startLoadingOutFifo,
    input  logic outFifoReady,
    input  logic outLoadDone,
    output logic loadExternal,
    output logic loadInternal,
    output logic isIFFT,
    output logic loadOutBuffer,
    output logic calculating,
    output logic aDone
);

    ctrlStateT state;
    ctrlStateT nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////
    // Next state and outputs
    //////////////////////////////

    always_comb begin
        nextState = state;
        calculating = 1'b0;
        loadExternal = 1'b0;
        loadInternal = 1'b0;
        isIFFT = 1'b0;
        loadOutBuffer = 1'b0;
        aDone = 1'b0;

        case (state)
            // Forward wins a tie
            IDLE: begin
                if (startF) begin
                    nextState = IDLE_LOADF;
                end else if (startI) begin
                    nextState = IDLE_LOADI;
                end
            end

            // Wait for samples, inverse job
            IDLE_LOADI: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGI;
                end else if (startLoadingRam) begin
                    nextState = LOADI;
                end
            end

            LOADI: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (inFifoEmpty || loadExternalDone) begin
                    nextState = IDLE_LOADI;
                end
            end

            // Wait for samples, forward job
            IDLE_LOADF: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGF;
                end else if (startLoadingRam) begin
                    nextState = LOADF;
                end
            end

            LOADF: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (inFifoEmpty || loadExternalDone) begin
                    nextState = IDLE_LOADF;
                end
            end

            CALCULATINGF: begin
                calculating = 1'b1;
                loadInternal = 1'b1;
                if (done) begin
                    nextState = IDLE_LOADOUT;
                end
            end

            CALCULATINGI: begin
                calculating = 1'b1;
                loadInternal = 1'b1;
                isIFFT = 1'b1;
                if (done) begin
                    nextState = IDLE_LOADOUT;
                end
            end

            // Unload only while the sink is ready
            IDLE_LOADOUT: begin
                calculating = 1'b1;
                if (outLoadDone) begin
                    nextState = DONE;
                end else if (startLoadingOutFifo) begin
                    nextState = LOADOUT;
                end
            end

            LOADOUT: begin
                calculating = 1'b1;
                loadOutBuffer = 1'b1;
                if (outFifoReady || outLoadDone) begin
                    nextState = IDLE_LOADOUT;
                end
            end

            DONE: begin
                calculating = 1'b1;
                aDone = 1'b1;
                nextState = IDLE;
            end

            default: nextState = IDLE;
        endcase
    end

endmodule

//--- common/fftPkg.sv
`include "fft_defs.svh"

package fftPkg;

    // Real or imaginary parts
    typedef logic signed [`SAMPLE_W-1:0] sampleT;
    typedef logic signed [`RESULT_W-1:0] resultT;

    // Buffer entry index
    typedef logic [$clog2(`FFT_POINTS)-1:0] pointIdxT;

    typedef struct packed {
        sampleT re;
        sampleT im;
    } cplxSampleT;

    typedef struct packed {
        resultT re;
        resultT im;
    } cplxResultT;

    // Job sequencing states
    typedef enum logic [3:0] {
        IDLE, IDLE_LOADI, IDLE_LOADF, LOADI, LOADF,
        CALCULATINGF, CALCULATINGI, IDLE_LOADOUT, LOADOUT, DONE
    } ctrlStateT;

endpackage

//--- common/fft_defs.svh
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

//////////////////////////////
// Transform size
//////////////////////////////

// Whole frame held in the sample buffer
`define FFT_POINTS 4

//////////////////////////////
// Data widths
//////////////////////////////

`define SAMPLE_W 16

// Two bits of growth for the unscaled forward sum
`define RESULT_W 18

`endif
